//--- bench/tinyEvgTb.sv
// Testbench for the tiny event generator
// Applies a table of traffic phases and decodes the link word stream,
// checking commas, queued events, heartbeat, PPS seconds and the bus byte

`timescale 1ns/1ps

module tinyEvgTb import evgPkg::*;;

    localparam int evgClockRate = 2000000;
    localparam int secondsWidth = 32;
    localparam int fifoDepth = 8;
    localparam int numRows = 7;

    // One traffic phase with the counts the decoder should see in it
    typedef struct packed {
        int phaseLen;
        int strobeCount;
        int strobeBase;
        int hbInterval;
        int ppsStart;
        int ppsWidth;
        int ppsGap;
        logic [31:0] secondsValue;
        logic busRandom;
        int expFifo;
        int expHeartbeat;
        int expMarker;
        int expToggles;
        logic expOverflow;
        logic lossy;
    } phaseRowT;

    logic evgTxClk;
    logic reset;
    eventCodeT eventCode;
    logic eventStrobe;
    logic [31:0] heartbeatInterval;
    logic ppsMarker;
    logic [secondsWidth-1:0] seconds;
    busByteT distributedBus;
    txWordT evgTxWord;
    txIsKT evgTxIsK;
    logic ppsToggle;
    logic fifoOverflow;

    phaseRowT rows [numRows];
    int rowCount = 0;
    int curRow = 0;
    integer seed = 70;
    int cycleCount = 0;
    int cycleLimit = 0;
    int streamErrors = 0;
    int phaseErrors = 0;

    // Decoder state, cleared by the driver at the start of each phase
    eventCodeT sentCodes [$];
    int matchIdx = 0;
    int fifoDelivered = 0;
    int hbCount = 0;
    int lastHbWord = -1;
    int markerCount = 0;
    int secondsDone = 0;
    int toggleCount = 0;

    // Decoder state that runs across phases
    logic resetWordSeen = 1'b0;
    logic seenComma = 1'b0;
    int sinceComma = 0;
    int eventsSinceComma = 0;
    int wordIndex = 0;
    logic inSeconds = 1'b0;
    int shiftCount = 0;
    int gapWords = 0;
    logic [31:0] assembled = '0;
    logic lastToggle = 1'b0;
    busByteT lastBus = '0;
    logic busArmed = 1'b0;

    tinyEvg #(
        .evgClockRate(evgClockRate),
        .secondsWidth(secondsWidth),
        .fifoDepth(fifoDepth)
    ) uut (
        .evgTxClk(evgTxClk),
        .reset(reset),
        .eventCode(eventCode),
        .eventStrobe(eventStrobe),
        .heartbeatInterval(heartbeatInterval),
        .ppsMarker(ppsMarker),
        .seconds(seconds),
        .distributedBus(distributedBus),
        .evgTxWord(evgTxWord),
        .evgTxIsK(evgTxIsK),
        .ppsToggle(ppsToggle),
        .fifoOverflow(fifoOverflow)
    );

    initial begin
        evgTxClk = 1'b0;
        forever #20 evgTxClk = ~evgTxClk;
    end

    task automatic addRow(input int len, input int strobes, input int base, input int hb,
                          input int pStart, input int pWidth, input int pGap,
                          input logic [31:0] secVal, input logic busRnd, input int eFifo,
                          input int eHb, input int eMark, input int eTog,
                          input logic eOvf, input logic lossyRow);
        phaseRowT row;
        row.phaseLen = len;
        row.strobeCount = strobes;
        row.strobeBase = base;
        row.hbInterval = hb;
        row.ppsStart = pStart;
        row.ppsWidth = pWidth;
        row.ppsGap = pGap;
        row.secondsValue = secVal;
        row.busRandom = busRnd;
        row.expFifo = eFifo;
        row.expHeartbeat = eHb;
        row.expMarker = eMark;
        row.expToggles = eTog;
        row.expOverflow = eOvf;
        row.lossy = lossyRow;
        rows[rowCount] = row;
        rowCount++;
    endtask

    // Phase counts checked once the phase has fully drained
    task automatic checkPhase(input int r);
        if (rows[r].lossy) begin
            assert (fifoDelivered < rows[r].strobeCount && fifoDelivered >= fifoDepth) else begin
                phaseErrors++;
                $display("Error at %0t: phase %0d delivered %0d of %0d strobes, expected a loss",
                         $time, r, fifoDelivered, rows[r].strobeCount);
            end
        end else begin
            assert (fifoDelivered == rows[r].expFifo) else begin
                phaseErrors++;
                $display("Error at %0t: phase %0d delivered %0d events, expected %0d",
                         $time, r, fifoDelivered, rows[r].expFifo);
            end
        end
        assert (hbCount == rows[r].expHeartbeat) else begin
            phaseErrors++;
            $display("Error at %0t: phase %0d saw %0d heartbeats, expected %0d",
                     $time, r, hbCount, rows[r].expHeartbeat);
        end
        assert (markerCount == rows[r].expMarker && secondsDone == rows[r].expMarker) else begin
            phaseErrors++;
            $display("Error at %0t: phase %0d saw %0d markers and %0d seconds words, expected %0d",
                     $time, r, markerCount, secondsDone, rows[r].expMarker);
        end
        assert (toggleCount == rows[r].expToggles) else begin
            phaseErrors++;
            $display("Error at %0t: phase %0d saw %0d PPS toggles, expected %0d",
                     $time, r, toggleCount, rows[r].expToggles);
        end
        assert (fifoOverflow == rows[r].expOverflow) else begin
            phaseErrors++;
            $display("Error at %0t: phase %0d overflow flag %0b, expected %0b",
                     $time, r, fifoOverflow, rows[r].expOverflow);
        end
    endtask

    task automatic runPhase(input int r);
        int c;
        int pEnd;
        logic pulse;
        curRow = r;
        sentCodes.delete();
        matchIdx = 0;
        fifoDelivered = 0;
        hbCount = 0;
        lastHbWord = -1;
        markerCount = 0;
        secondsDone = 0;
        toggleCount = 0;
        pEnd = rows[r].ppsStart + rows[r].ppsWidth;
        for (c = 0; c < rows[r].phaseLen; c++) begin
            @(posedge evgTxClk);
            if (c == 0) begin
                heartbeatInterval <= rows[r].hbInterval;
                seconds <= rows[r].secondsValue;
            end
            // Strobes run back to back from the third cycle of the phase
            if (c >= 2 && c < 2 + rows[r].strobeCount) begin
                eventStrobe <= 1'b1;
                eventCode <= eventCodeT'(rows[r].strobeBase + c - 2);
                sentCodes.push_back(eventCodeT'(rows[r].strobeBase + c - 2));
            end else begin
                eventStrobe <= 1'b0;
            end
            // Optional second pulse of the same width after a short low gap
            pulse = (rows[r].ppsWidth > 0) && (c >= rows[r].ppsStart) && (c < pEnd);
            if (rows[r].ppsGap > 0 && c >= pEnd + rows[r].ppsGap &&
                c < pEnd + rows[r].ppsGap + rows[r].ppsWidth) begin
                pulse = 1'b1;
            end
            ppsMarker <= pulse;
            distributedBus <= rows[r].busRandom ? busByteT'($random(seed)) : busByteT'(c);
        end
        checkPhase(r);
    endtask

    initial begin : mainSequence
        int r;
        reset = 1'b1;
        eventCode = '0;
        eventStrobe = 1'b0;
        heartbeatInterval = '0;
        ppsMarker = 1'b0;
        seconds = '0;
        distributedBus = '0;
        // len, strobes, base, hb, ppsStart, width, gap, seconds, bus, fifo, hb, mark, tog, ovf
        addRow(60, 0, 0, 0, 0, 0, 0, 32'h0, 1'b1, 0, 0, 0, 0, 1'b0, 1'b0);
        addRow(60, 8, 8'h20, 0, 0, 0, 0, 32'h0, 1'b1, 8, 0, 0, 0, 1'b0, 1'b0);
        addRow(450, 0, 0, 100, 0, 0, 0, 32'h0, 1'b0, 0, 4, 0, 0, 1'b0, 1'b0);
        addRow(150, 0, 0, 20, 0, 0, 0, 32'h0, 1'b1, 0, 0, 0, 0, 1'b0, 1'b0);
        addRow(250, 0, 0, 0, 30, 5, 0, 32'hA5C31E07, 1'b1, 0, 0, 1, 1, 1'b0, 1'b0);
        addRow(250, 0, 0, 0, 30, 5, 10, 32'h12345678, 1'b1, 0, 0, 1, 1, 1'b0, 1'b0);
        // Forced commas let the FIFO fill by one entry every eight words
        addRow(200, 96, 8'h80, 0, 0, 0, 0, 32'h0, 1'b1, 0, 0, 0, 0, 1'b1, 1'b1);
        cycleLimit = 200;
        for (r = 0; r < rowCount; r++) begin
            cycleLimit += rows[r].phaseLen;
        end
        repeat (5) @(posedge evgTxClk);
        reset <= 1'b0;
        for (r = 0; r < rowCount; r++) begin
            runPhase(r);
        end
        $display("Checks done: %0d stream errors, %0d phase errors", streamErrors, phaseErrors);
        if (streamErrors == 0 && phaseErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Ends a run that has gone past its expected length
    initial begin : watchdog
        wait (cycleLimit != 0);
        while (cycleCount < cycleLimit) begin
            @(posedge evgTxClk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Simulation failed");
        $finish;
    end

    // Outputs settle after the rising edge, so the stream is read on the falling edge
    always @(negedge evgTxClk) begin : streamDecoder
        eventCodeT lowByte;
        logic isComma;
        lowByte = evgTxWord[7:0];
        isComma = evgTxIsK[0];
        if (busArmed) begin
            assert (evgTxWord[15:8] == lastBus) else begin
                streamErrors++;
                $display("Error at %0t: bus byte %h, expected %h",
                         $time, evgTxWord[15:8], lastBus);
            end
        end
        lastBus = distributedBus;
        busArmed = !reset;
        if (!reset) begin
            if (ppsToggle != lastToggle) begin
                toggleCount++;
            end
            lastToggle = ppsToggle;
            assert (!evgTxIsK[1] && (!isComma || lowByte == evCodeComma)) else begin
                streamErrors++;
                $display("Error at %0t: bad K flags %b with code %h", $time, evgTxIsK, lowByte);
            end
            if (!seenComma) begin
                if (!resetWordSeen) begin
                    // The reset value is still on the link in the first cycle out of reset
                    assert (evgTxWord == '0 && evgTxIsK == '0) else begin
                        streamErrors++;
                        $display("Error at %0t: word %h after reset, expected zero",
                                 $time, evgTxWord);
                    end
                    resetWordSeen = 1'b1;
                end else begin
                    // The first scheduled word after reset is a comma
                    assert (isComma) else begin
                        streamErrors++;
                        $display("Error at %0t: first word %h is not a comma", $time, lowByte);
                    end
                    seenComma = 1'b1;
                    sinceComma = 0;
                    eventsSinceComma = 0;
                end
            end else begin
                wordIndex++;
                sinceComma++;
                gapWords++;
                if (isComma) begin
                    // With nothing but null words in between, idle commas are evenly spaced
                    if (eventsSinceComma == 0) begin
                        assert (sinceComma == commaIdleWords) else begin
                            streamErrors++;
                            $display("Error at %0t: idle comma after %0d words", $time, sinceComma);
                        end
                    end
                    sinceComma = 0;
                    eventsSinceComma = 0;
                end else begin
                    assert (sinceComma < 9) else begin
                        streamErrors++;
                        $display("Error at %0t: %0d words without a comma", $time, sinceComma);
                    end
                    if (lowByte != 8'h00) begin
                        eventsSinceComma++;
                    end
                    if (lowByte == evCodeHeartbeat) begin
                        if (lastHbWord >= 0) begin
                            assert (wordIndex - lastHbWord == rows[curRow].hbInterval) else begin
                                streamErrors++;
                                $display("Error at %0t: heartbeat spacing %0d, expected %0d",
                                         $time, wordIndex - lastHbWord, rows[curRow].hbInterval);
                            end
                        end
                        lastHbWord = wordIndex;
                        hbCount++;
                    end else if (lowByte == evCodeSecondsMarker) begin
                        markerCount++;
                        inSeconds = 1'b1;
                        shiftCount = 0;
                        gapWords = 0;
                        assembled = '0;
                    end else if (lowByte == evCodeShiftZero || lowByte == evCodeShiftOne) begin
                        assert (inSeconds && gapWords >= secondsGapWords) else begin
                            streamErrors++;
                            $display("Error at %0t: shift event %0d words after the last one",
                                     $time, gapWords);
                        end
                        gapWords = 0;
                        assembled = {assembled[30:0], lowByte == evCodeShiftOne};
                        shiftCount++;
                        if (shiftCount == secondsWidth) begin
                            inSeconds = 1'b0;
                            secondsDone++;
                            assert (assembled == rows[curRow].secondsValue) else begin
                                streamErrors++;
                                $display("Error at %0t: seconds %h, expected %h", $time,
                                         assembled, rows[curRow].secondsValue);
                            end
                        end
                    end else if (lowByte != 8'h00) begin
                        // Any other data code is a queued external event
                        fifoDelivered++;
                        if (rows[curRow].lossy) begin
                            while (matchIdx < sentCodes.size() &&
                                   sentCodes[matchIdx] != lowByte) begin
                                matchIdx++;
                            end
                        end
                        assert (matchIdx < sentCodes.size() &&
                                sentCodes[matchIdx] == lowByte) else begin
                            streamErrors++;
                            $display("Error at %0t: event %h is out of strobe order", $time, lowByte);
                        end
                        matchIdx++;
                    end
                end
            end
        end
    end

endmodule

//--- list.f
src/evgPkg.sv
src/heartbeatTimer.sv
src/ppsCapture.sv
src/eventFifo.sv
src/txScheduler.sv
src/tinyEvg.sv
bench/tinyEvgTb.sv

//--- src/eventFifo.sv
// External event FIFO
// First-word-fallthrough register FIFO for strobed event codes, with a
// sticky overflow flag for strobes that arrive while it is full

`timescale 1ns/1ps

module eventFifo import evgPkg::*; #(
    parameter int fifoDepth = 8
) (
    input  logic      evgTxClk,
    input  logic      reset,
    input  eventCodeT eventCode,
    input  logic      eventStrobe,
    input  logic      fifoPop,
    output eventCodeT fifoCode,
    output logic      fifoValid,
    output logic      fifoOverflow
);

    // Depth is a power of two, so the pointers wrap by themselves
    localparam int addrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam int countWidth = $clog2(fifoDepth + 1);

    eventCodeT fifoMem [fifoDepth];

    logic [addrWidth-1:0] wrPtr;
    logic [addrWidth-1:0] rdPtr;
    logic [countWidth-1:0] fifoCount;

    logic fifoFull;
    logic doPush;
    logic doPop;

    assign fifoFull = (fifoCount == countWidth'(fifoDepth));

    // A strobe into a full FIFO is dropped, even if a pop happens alongside
    assign doPush = eventStrobe && !fifoFull;
    assign doPop = fifoPop && fifoValid;

    // The head entry is visible without a read cycle
    assign fifoCode = fifoMem[rdPtr];
    assign fifoValid = (fifoCount != '0);

    // Storage holds payload only
    always_ff @(posedge evgTxClk) begin
        if (doPush) begin
            fifoMem[wrPtr] <= eventCode;
        end
    end

    always_ff @(posedge evgTxClk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fifoCount <= '0;
            fifoOverflow <= 1'b0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            if (doPush && !doPop) begin
                fifoCount <= fifoCount + 1'b1;
            end else if (doPop && !doPush) begin
                fifoCount <= fifoCount - 1'b1;
            end
            // Stays set until the next reset
            if (eventStrobe && fifoFull) begin
                fifoOverflow <= 1'b1;
            end
        end
    end

endmodule

//--- src/evgPkg.sv
// Shared definitions for the tiny event generator
// Word types, event codes, link spacing rules and the scheduler source enum

package evgPkg;

    // An event or comma code in the low byte of the link word
    typedef logic [7:0] eventCodeT;

    // One byte of the distributed bus, carried in the high byte
    typedef logic [7:0] busByteT;

    // The full transmit word and its per-byte K flags
    typedef logic [15:0] txWordT;
    typedef logic [1:0] txIsKT;

    // Event codes understood by the receivers
    localparam eventCodeT evCodeShiftZero = 8'h70;
    localparam eventCodeT evCodeShiftOne = 8'h71;
    localparam eventCodeT evCodeHeartbeat = 8'h7A;
    localparam eventCodeT evCodeSecondsMarker = 8'h7D;

    // K28.5, sent with the K flag set so receivers keep word alignment
    localparam eventCodeT evCodeComma = 8'hBC;

    // Link spacing, all counted in transmit words
    localparam int commaForceWords = 8;
    localparam int commaIdleWords = 4;
    localparam int secondsGapWords = 4;

    // Heartbeat intervals at or below this many cycles turn the heartbeat off
    localparam int heartbeatMinInterval = 20;

    // Source of the word being scheduled, listed from highest priority down
    typedef enum logic [2:0] {
        selComma,
        selFifo,
        selHeartbeat,
        selMarker,
        selShift,
        selIdleComma,
        selNull
    } txSelT;

endpackage

//--- src/heartbeatTimer.sv
// Heartbeat interval timer
// Raises a one-cycle heartbeat request every heartbeatInterval cycles

`timescale 1ns/1ps

module heartbeatTimer import evgPkg::*; (
    input  logic        evgTxClk,
    input  logic        reset,
    input  logic [31:0] heartbeatInterval,
    output logic        heartbeatRequest
);

    // Cycles left until the next request
    logic [31:0] heartbeatCounter;

    // Set once the counter has been loaded from a valid interval
    logic running;

    always_ff @(posedge evgTxClk) begin
        if (reset) begin
            heartbeatCounter <= '0;
            running <= 1'b0;
            heartbeatRequest <= 1'b0;
        end else if (heartbeatInterval > heartbeatMinInterval) begin
            if (!running) begin
                // First load after reset or after the interval became valid
                // The first request follows a full interval from here
                heartbeatCounter <= heartbeatInterval - 1'b1;
                running <= 1'b1;
                heartbeatRequest <= 1'b0;
            end else if (heartbeatCounter == '0) begin
                heartbeatCounter <= heartbeatInterval - 1'b1;
                heartbeatRequest <= 1'b1;
            end else begin
                heartbeatCounter <= heartbeatCounter - 1'b1;
                heartbeatRequest <= 1'b0;
            end
        end else begin
            // Disabled, so the counter parks at zero and nothing is requested
            heartbeatCounter <= '0;
            running <= 1'b0;
            heartbeatRequest <= 1'b0;
        end
    end

endmodule

//--- src/ppsCapture.sv
// Pulse-per-second capture
// Synchronizes and debounces the PPS marker, flips ppsToggle on each
// accepted rising edge and latches the seconds value on that same edge

`timescale 1ns/1ps

module ppsCapture #(
    parameter int evgClockRate = 125000000,
    parameter int secondsWidth = 32
) (
    input  logic                    evgTxClk,
    input  logic                    reset,
    input  logic                    ppsMarker,
    input  logic [secondsWidth-1:0] seconds,
    output logic                    ppsToggle,
    output logic [secondsWidth-1:0] secondsLatched
);

    // The marker must stay low for 10 us before the next edge is taken
    localparam int debounceCycles = evgClockRate / 100000;
    localparam int debounceReload = (debounceCycles > 0) ? debounceCycles - 1 : 0;
    localparam int timerWidth = (debounceReload > 0) ? $clog2(debounceReload + 1) : 1;

    // Two-flop synchronizer for the asynchronous marker
    logic ppsMeta;
    logic ppsSync;

    // Low time still needed before the detector is armed again
    logic [timerWidth-1:0] debounceTimer;

    // High when a rising edge may be accepted
    logic armed;

    always_ff @(posedge evgTxClk) begin
        if (reset) begin
            ppsMeta <= 1'b0;
            ppsSync <= 1'b0;
            ppsToggle <= 1'b0;
            // Start disarmed so a marker already high at reset is not an edge
            armed <= 1'b0;
            debounceTimer <= timerWidth'(debounceReload);
        end else begin
            ppsMeta <= ppsMarker;
            ppsSync <= ppsMeta;
            if (ppsSync) begin
                // Any high cycle restarts the low-time count
                armed <= 1'b0;
                debounceTimer <= timerWidth'(debounceReload);
                if (armed) begin
                    ppsToggle <= ~ppsToggle;
                end
            end else if (debounceTimer != '0) begin
                debounceTimer <= debounceTimer - 1'b1;
            end else begin
                armed <= 1'b1;
            end
        end
    end

    // The seconds input is stable around the pulse, so it is taken directly
    // on the edge that flips the toggle
    always_ff @(posedge evgTxClk) begin
        if (ppsSync && armed) begin
            secondsLatched <= seconds;
        end
    end

endmodule

//--- src/tinyEvg.sv
// Tiny event generator top level
// Connects the external event FIFO, heartbeat timer and PPS capture to the
// transmit scheduler that builds the 16-bit link word

`timescale 1ns/1ps

module tinyEvg import evgPkg::*; #(
    parameter int evgClockRate = 125000000,
    parameter int secondsWidth = 32,
    parameter int fifoDepth = 8
) (
    input  logic                    evgTxClk,
    input  logic                    reset,
    input  eventCodeT               eventCode,
    input  logic                    eventStrobe,
    input  logic [31:0]             heartbeatInterval,
    input  logic                    ppsMarker,
    input  logic [secondsWidth-1:0] seconds,
    input  busByteT                 distributedBus,
    output txWordT                  evgTxWord,
    output txIsKT                   evgTxIsK,
    output logic                    ppsToggle,
    output logic                    fifoOverflow
);

    // FIFO head and pop handshake to the scheduler
    eventCodeT fifoCode;
    logic fifoValid;
    logic fifoPop;

    logic heartbeatRequest;
    logic [secondsWidth-1:0] secondsLatched;

    eventFifo #(
        .fifoDepth(fifoDepth)
    ) eventFifoInst (
        .evgTxClk(evgTxClk),
        .reset(reset),
        .eventCode(eventCode),
        .eventStrobe(eventStrobe),
        .fifoPop(fifoPop),
        .fifoCode(fifoCode),
        .fifoValid(fifoValid),
        .fifoOverflow(fifoOverflow)
    );

    heartbeatTimer heartbeatTimerInst (
        .evgTxClk(evgTxClk),
        .reset(reset),
        .heartbeatInterval(heartbeatInterval),
        .heartbeatRequest(heartbeatRequest)
    );

    // PPS marker and seconds come from another time base
    ppsCapture #(
        .evgClockRate(evgClockRate),
        .secondsWidth(secondsWidth)
    ) ppsCaptureInst (
        .evgTxClk(evgTxClk),
        .reset(reset),
        .ppsMarker(ppsMarker),
        .seconds(seconds),
        .ppsToggle(ppsToggle),
        .secondsLatched(secondsLatched)
    );

    txScheduler #(
        .secondsWidth(secondsWidth)
    ) txSchedulerInst (
        .evgTxClk(evgTxClk),
        .reset(reset),
        .fifoCode(fifoCode),
        .fifoValid(fifoValid),
        .heartbeatRequest(heartbeatRequest),
        .ppsToggle(ppsToggle),
        .secondsLatched(secondsLatched),
        .distributedBus(distributedBus),
        .fifoPop(fifoPop),
        .evgTxWord(evgTxWord),
        .evgTxIsK(evgTxIsK)
    );

endmodule

//--- src/txScheduler.sv
// Transmit scheduler
// Picks one source per cycle by fixed priority, serializes the latched
// seconds value as shift events, inserts commas and registers the link word

`timescale 1ns/1ps

module txScheduler import evgPkg::*; #(
    parameter int secondsWidth = 32
) (
    input  logic                    evgTxClk,
    input  logic                    reset,
    input  eventCodeT               fifoCode,
    input  logic                    fifoValid,
    input  logic                    heartbeatRequest,
    input  logic                    ppsToggle,
    input  logic [secondsWidth-1:0] secondsLatched,
    input  busByteT                 distributedBus,
    output logic                    fifoPop,
    output txWordT                  evgTxWord,
    output txIsKT                   evgTxIsK
);

    localparam int wordCountWidth = $clog2(commaForceWords + 1);
    localparam int gapCountWidth = $clog2(secondsGapWords + 1);
    localparam int bitCountWidth = $clog2(secondsWidth + 1);

    // Words since the last comma, saturating at the forced-comma limit
    logic [wordCountWidth-1:0] wordCount;

    // Words since the last marker or shift, saturating at the gap
    logic [gapCountWidth-1:0] gapCount;

    // Seconds bits still to send, most significant bit first
    logic [secondsWidth-1:0] secondsShift;
    logic [bitCountWidth-1:0] bitCount;

    // Follows ppsToggle once the marker for each new second is sent
    logic ppsMatch;

    txSelT txSel;
    eventCodeT nextCode;
    logic nextIsK;

    // One decision per cycle in priority order
    always_comb begin
        txSel = selNull;
        if (wordCount >= commaForceWords) begin
            txSel = selComma;
        end else if (fifoValid) begin
            txSel = selFifo;
        end else if (heartbeatRequest) begin
            // A heartbeat that loses this slot is dropped, not held
            txSel = selHeartbeat;
        end else if (ppsMatch != ppsToggle) begin
            txSel = selMarker;
        end else if ((bitCount != '0) && (gapCount >= secondsGapWords)) begin
            txSel = selShift;
        end else if (wordCount >= commaIdleWords) begin
            txSel = selIdleComma;
        end
    end

    // Code and K flag for the chosen source
    always_comb begin
        nextIsK = 1'b0;
        case (txSel)
            selComma, selIdleComma: begin
                nextCode = evCodeComma;
                nextIsK = 1'b1;
            end
            selFifo: nextCode = fifoCode;
            selHeartbeat: nextCode = evCodeHeartbeat;
            selMarker: nextCode = evCodeSecondsMarker;
            selShift: begin
                nextCode = secondsShift[secondsWidth-1] ? evCodeShiftOne : evCodeShiftZero;
            end
            default: nextCode = '0;
        endcase
    end

    // The head entry leaves the FIFO only in the cycle it is scheduled
    assign fifoPop = (txSel == selFifo);

    always_ff @(posedge evgTxClk) begin
        if (reset) begin
            // Start saturated so the first scheduled word is a comma
            wordCount <= wordCountWidth'(commaForceWords);
            gapCount <= gapCountWidth'(secondsGapWords);
            bitCount <= '0;
            ppsMatch <= 1'b0;
        end else begin
            if (nextIsK) begin
                wordCount <= wordCountWidth'(1);
            end else if (wordCount < commaForceWords) begin
                wordCount <= wordCount + 1'b1;
            end

            if (txSel == selMarker) begin
                // A new second restarts the serializer even mid-stream
                ppsMatch <= ~ppsMatch;
                bitCount <= bitCountWidth'(secondsWidth);
                gapCount <= gapCountWidth'(1);
            end else if (txSel == selShift) begin
                bitCount <= bitCount - 1'b1;
                gapCount <= gapCountWidth'(1);
            end else if (gapCount < secondsGapWords) begin
                gapCount <= gapCount + 1'b1;
            end
        end
    end

    // Seconds payload register
    always_ff @(posedge evgTxClk) begin
        if (txSel == selMarker) begin
            secondsShift <= secondsLatched;
        end else if (txSel == selShift) begin
            secondsShift <= {secondsShift[secondsWidth-2:0], 1'b0};
        end
    end

    // Link word, with the bus byte sampled alongside the chosen code
    // Only the low byte can carry a K character
    always_ff @(posedge evgTxClk) begin
        if (reset) begin
            evgTxWord <= '0;
            evgTxIsK <= '0;
        end else begin
            evgTxWord <= {distributedBus, nextCode};
            evgTxIsK <= {1'b0, nextIsK};
        end
    end

endmodule
